//--- tb.f
design/simple_processor_pkg.sv
design/reg_file.sv
design/alu.sv
design/lsu.sv
design/ins_dec.sv
design/simple_processor.sv
tb/sp_mem_model.sv
tb/simple_processor_assertions.sv
tb/tb_simple_processor.sv

//--- tb/tb_simple_processor.sv
/*
  Testbench top. Each table row assembles a short program ending in HALT,
  runs it from its boot address and compares fetch addresses and stores.
*/

`timescale 1ns/1ns

module tb_simple_processor
  import simple_processor_pkg::*;
();

  logic                  clk_i = 1'b0;
  logic                  arst_ni;
  logic [ADDR_WIDTH-1:0] boot_addr_i;
  logic                  imem_req_o;
  logic                  imem_ack_i;
  logic                  dmem_req_o;
  logic                  dmem_we_o;
  logic                  dmem_ack_i;
  logic                  halted_o;
  logic [ADDR_WIDTH-1:0] imem_addr_o;
  logic [ADDR_WIDTH-1:0] dmem_addr_o;
  logic [DATA_WIDTH-1:0] imem_rdata_i;
  logic [DATA_WIDTH-1:0] dmem_wdata_o;
  logic [DATA_WIDTH-1:0] dmem_rdata_i;
  logic                  wr_valid;
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [DATA_WIDTH-1:0] wr_data;

  // Test table
  string                 row_name [$];
  opcode_e               row_op [$];
  logic [8:0]            row_a [$];
  logic [8:0]            row_b [$];
  logic [ADDR_WIDTH-1:0] row_boot [$];
  bit                    row_rand [$];
  logic [2:0]            row_dst [$];

  // Program and expected results of the current row
  logic [DATA_WIDTH-1:0] prog [$];
  logic [ADDR_WIDTH-1:0] exp_fetch [$];
  logic [ADDR_WIDTH-1:0] got_fetch [$];
  logic [ADDR_WIDTH-1:0] exp_st_addr [$];
  logic [ADDR_WIDTH-1:0] got_st_addr [$];
  logic [DATA_WIDTH-1:0] exp_st_data [$];
  logic [DATA_WIDTH-1:0] got_st_data [$];

  logic [31:0] lfsr_q = 32'haf0;
  int          value_errors = 0;
  int          other_errors = 0;
  int          assert_errors = 0;

  always #4 clk_i = ~clk_i;

  simple_processor simple_processor_inst (.*);

  sp_mem_model mem_model_inst (
    .clk_i, .arst_ni,
    .imem_req_i (imem_req_o), .imem_addr_i (imem_addr_o),
    .imem_rdata_o (imem_rdata_i), .imem_ack_o (imem_ack_i),
    .dmem_req_i (dmem_req_o), .dmem_we_i (dmem_we_o), .dmem_addr_i (dmem_addr_o),
    .dmem_wdata_i (dmem_wdata_o), .dmem_rdata_o (dmem_rdata_i), .dmem_ack_o (dmem_ack_i),
    .wr_valid_o (wr_valid), .wr_addr_o (wr_addr), .wr_data_o (wr_data)
  );

  // Observed fetches and stores
  always @(posedge clk_i) begin
    if (arst_ni && imem_req_o && imem_ack_i) begin
      got_fetch.push_back(imem_addr_o);
    end
    if (arst_ni && wr_valid) begin
      got_st_addr.push_back(wr_addr);
      got_st_data.push_back(wr_data);
    end
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] lfsr_bits(int n);
    logic [31:0] bits;
    bits = '0;
    for (int k = 0; k < n; k++) begin
      bits   = {bits[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return bits;
  endfunction

  function automatic logic [15:0] enc_r(opcode_e op, logic [2:0] rd, logic [2:0] rs1,
                                        logic [2:0] rs2);
    return {op, rd, rs1, rs2, 3'b000};
  endfunction

  function automatic logic [15:0] enc_i6(opcode_e op, logic [2:0] rd, logic [2:0] rs1,
                                         logic [5:0] imm);
    return {op, rd, rs1, imm};
  endfunction

  function automatic logic [15:0] enc_i9(opcode_e op, logic [2:0] rd, logic [8:0] imm);
    return {op, rd, imm};
  endfunction

  // Register operation result wrapped to 16 bits
  function automatic logic [15:0] expected_alu(opcode_e op, logic [15:0] a, logic [15:0] b);
    case (op)
      OP_ADD, OP_ADDI: return a + b;
      OP_SUB:          return a - b;
      OP_AND:          return a & b;
      OP_OR:           return a | b;
      default:         return a ^ b;
    endcase
  endfunction

  task automatic add_row(string name, opcode_e op, logic [8:0] a, logic [8:0] b,
                         logic [ADDR_WIDTH-1:0] boot, bit rnd, logic [2:0] dst);
    row_name.push_back(name);
    row_op.push_back(op);
    row_a.push_back(a);
    row_b.push_back(b);
    row_boot.push_back(boot);
    row_rand.push_back(rnd);
    row_dst.push_back(dst);
  endtask

  task automatic check_addr(string name, logic [ADDR_WIDTH-1:0] exp,
                            logic [ADDR_WIDTH-1:0] act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_data(string name, logic [DATA_WIDTH-1:0] exp,
                            logic [DATA_WIDTH-1:0] act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_state(string name, logic exp, logic act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %b actual %b", name, exp, act);
      value_errors++;
    end
  endtask

  ////////////////////////////////////////
  // Program assembly and expectations
  ////////////////////////////////////////

  task automatic build_program(opcode_e op, logic [8:0] a, logic [8:0] b, logic [2:0] dst,
                               logic [ADDR_WIDTH-1:0] boot);
    logic [15:0] res;
    logic [15:0] target;
    prog.delete();
    exp_fetch.delete();
    exp_st_addr.delete();
    exp_st_data.delete();
    prog.push_back(enc_i9(OP_LDI, 3'd1, a));
    if (op == OP_LD) begin
      // Store, load into r4, store again elsewhere
      prog.push_back(enc_i6(OP_ST, 3'd1, 3'd0, 6'd4));
      prog.push_back(enc_i6(OP_LD, 3'd4, 3'd0, 6'd4));
      prog.push_back(enc_i6(OP_ST, 3'd4, 3'd0, 6'd12));
      exp_st_addr.push_back(16'd4);
      exp_st_data.push_back({7'd0, a});
      exp_st_addr.push_back(16'd12);
      exp_st_data.push_back({7'd0, a});
    end else if (op == OP_BEZ) begin
      prog.push_back(enc_i9(OP_BEZ, 3'd1, b));
      prog.push_back(enc_i9(OP_LDI, 3'd5, 9'd1));
      prog.push_back(enc_i6(OP_ST, 3'd5, 3'd0, 6'd8));
    end else begin
      if (op == OP_ADDI) begin
        prog.push_back(enc_i6(OP_ADDI, dst, 3'd1, b[5:0]));
        res = expected_alu(op, {7'd0, a}, 16'($signed(b[5:0])));
      end else begin
        prog.push_back(enc_i9(OP_LDI, 3'd2, b));
        prog.push_back(enc_r(op, dst, 3'd1, 3'd2));
        res = expected_alu(op, {7'd0, a}, {7'd0, b});
      end
      prog.push_back(enc_i6(OP_ST, dst, 3'd0, 6'd8));
      exp_st_addr.push_back(16'd8);
      // r0 always reads zero
      exp_st_data.push_back(dst == 3'd0 ? 16'd0 : res);
    end
    prog.push_back(enc_r(OP_HALT, 3'd0, 3'd0, 3'd0));
    for (int k = 0; k < prog.size(); k++) begin
      mem_model_inst.imem[(boot >> 1) + k] = prog[k];
    end
    // Branch target lands on HALT in every table row
    if (op == OP_BEZ && a == 9'd0) begin
      // BEZ sits at boot + 2
      target = boot + 16'd2 + 16'd2 + 16'(2 * $signed(b));
      exp_fetch.push_back(boot);
      exp_fetch.push_back(boot + 16'd2);
      exp_fetch.push_back(target);
    end else begin
      if (op == OP_BEZ) begin
        exp_st_addr.push_back(16'd8);
        exp_st_data.push_back(16'd1);
      end
      for (int k = 0; k < prog.size(); k++) begin
        exp_fetch.push_back(boot + 16'(2 * k));
      end
    end
  endtask

  ////////////////////////////////////////
  // Row execution
  ////////////////////////////////////////

  task automatic run_row(int r);
    logic [8:0] a;
    logic [8:0] b;
    int         cyc;
    bit         busy;
    a = row_a[r];
    b = row_b[r];
    if (row_rand[r]) begin
      a = lfsr_bits(9);
      b = lfsr_bits(9);
    end
    @(posedge clk_i);
    #1;
    arst_ni     = 1'b0;
    boot_addr_i = row_boot[r];
    for (int i = 0; i < 256; i++) begin
      mem_model_inst.imem[i] = '0;
    end
    build_program(row_op[r], a, b, row_dst[r], row_boot[r]);
    repeat (4) begin
      @(posedge clk_i);
      #1;
      check_state({row_name[r], " reset imem_req"}, 1'b0, imem_req_o);
      check_state({row_name[r], " reset dmem_req"}, 1'b0, dmem_req_o);
      check_state({row_name[r], " reset dmem_we"}, 1'b0, dmem_we_o);
      check_state({row_name[r], " reset halted"}, 1'b0, halted_o);
      check_addr({row_name[r], " reset imem_addr"}, '0, imem_addr_o);
    end
    got_fetch.delete();
    got_st_addr.delete();
    got_st_data.delete();
    arst_ni = 1'b1;
    cyc = 0;
    while (!halted_o && cyc < 500) begin
      @(posedge clk_i);
      #1;
      cyc++;
    end
    if (!halted_o) begin
      $display("%s: core did not halt within 500 cycles", row_name[r]);
      other_errors++;
    end
    check_state({row_name[r], " halted"}, 1'b1, halted_o);
    // Quiet window after HALT
    busy = 1'b0;
    cyc  = 0;
    while (cyc < 20) begin
      @(posedge clk_i);
      #1;
      busy |= imem_req_o | dmem_req_o;
      cyc++;
    end
    check_state({row_name[r], " request after halt"}, 1'b0, busy);
    if (got_fetch.size() != exp_fetch.size()) begin
      $display("%s: %0d fetches seen but %0d expected", row_name[r],
               got_fetch.size(), exp_fetch.size());
      other_errors++;
    end
    for (int k = 0; k < exp_fetch.size() && k < got_fetch.size(); k++) begin
      check_addr($sformatf("%s fetch %0d", row_name[r], k), exp_fetch[k], got_fetch[k]);
    end
    if (got_st_addr.size() != exp_st_addr.size()) begin
      $display("%s: %0d stores seen but %0d expected", row_name[r],
               got_st_addr.size(), exp_st_addr.size());
      other_errors++;
    end
    for (int k = 0; k < exp_st_addr.size() && k < got_st_addr.size(); k++) begin
      check_addr($sformatf("%s store addr %0d", row_name[r], k), exp_st_addr[k],
                 got_st_addr[k]);
      check_data($sformatf("%s store data %0d", row_name[r], k), exp_st_data[k],
                 got_st_data[k]);
    end
  endtask

  initial begin
    arst_ni     = 1'b0;
    boot_addr_i = '0;
    // Name, opcode, a, b, boot, random operands, destination
    add_row("add_basic", OP_ADD, 9'd100, 9'd23, 16'h0000, 0, 3'd3);
    add_row("sub_wrap", OP_SUB, 9'd5, 9'd300, 16'h0040, 0, 3'd3);
    add_row("and_rand", OP_AND, 9'd0, 9'd0, 16'h0100, 1, 3'd3);
    add_row("or_rand", OP_OR, 9'd0, 9'd0, 16'h0020, 1, 3'd6);
    add_row("xor_rand", OP_XOR, 9'd0, 9'd0, 16'h0062, 1, 3'd7);
    add_row("addi_neg", OP_ADDI, 9'd10, 9'h03b, 16'h0080, 0, 3'd3);
    add_row("addi_rand", OP_ADDI, 9'd0, 9'd0, 16'h00c4, 1, 3'd2);
    add_row("add_to_r0", OP_ADD, 9'd7, 9'd9, 16'h0010, 0, 3'd0);
    add_row("ld_st_rand", OP_LD, 9'd0, 9'd0, 16'h00a0, 1, 3'd4);
    add_row("ld_st_again", OP_LD, 9'd0, 9'd0, 16'h01a0, 1, 3'd4);
    add_row("bez_taken", OP_BEZ, 9'd0, 9'd2, 16'h0140, 0, 3'd1);
    add_row("bez_not_taken", OP_BEZ, 9'd5, 9'd2, 16'h0180, 0, 3'd1);
    for (int r = 0; r < row_name.size(); r++) begin
      run_row(r);
    end
    assert_errors = simple_processor_inst.simple_processor_sva_inst.fail_count;
    $display("Errors: %0d value mismatches, %0d other failures, %0d assertion failures",
             value_errors, other_errors, assert_errors);
    if (value_errors + other_errors + assert_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- tb/simple_processor_assertions.sv
/*
  Bound checks on the core ports. Disabled while reset is low.
*/

`timescale 1ns/1ns

module simple_processor_assertions
  import simple_processor_pkg::*;
(
  input logic                  clk_i,
  input logic                  arst_ni,
  input logic                  imem_req_o,
  input logic [ADDR_WIDTH-1:0] imem_addr_o,
  input logic                  imem_ack_i,
  input logic                  dmem_req_o,
  input logic                  dmem_we_o,
  input logic [ADDR_WIDTH-1:0] dmem_addr_o,
  input logic [DATA_WIDTH-1:0] dmem_wdata_o,
  input logic                  dmem_ack_i,
  input logic                  halted_o
);

  // Failed checks so far
  int unsigned fail_count = 0;

  // Pending fetch keeps its address
  imem_hold: assert property (@(posedge clk_i) disable iff (!arst_ni)
    imem_req_o && !imem_ack_i |=> imem_req_o && $stable(imem_addr_o))
    else begin
      fail_count++;
      $error("instruction request changed before ack");
    end

  // Pending data access keeps we, address and data
  dmem_hold: assert property (@(posedge clk_i) disable iff (!arst_ni)
    dmem_req_o && !dmem_ack_i |=> dmem_req_o && $stable(dmem_we_o) &&
      $stable(dmem_addr_o) && $stable(dmem_wdata_o))
    else begin
      fail_count++;
      $error("data request changed before ack");
    end

  one_port: assert property (@(posedge clk_i) disable iff (!arst_ni)
    !(imem_req_o && dmem_req_o))
    else begin
      fail_count++;
      $error("instruction and data requests high together");
    end

  halt_sticky: assert property (@(posedge clk_i) disable iff (!arst_ni)
    halted_o |=> halted_o)
    else begin
      fail_count++;
      $error("halted_o dropped without reset");
    end

endmodule

bind simple_processor simple_processor_assertions simple_processor_sva_inst (
  .clk_i        (clk_i),
  .arst_ni      (arst_ni),
  .imem_req_o   (imem_req_o),
  .imem_addr_o  (imem_addr_o),
  .imem_ack_i   (imem_ack_i),
  .dmem_req_o   (dmem_req_o),
  .dmem_we_o    (dmem_we_o),
  .dmem_addr_o  (dmem_addr_o),
  .dmem_wdata_o (dmem_wdata_o),
  .dmem_ack_i   (dmem_ack_i),
  .halted_o     (halted_o)
);

//--- tb/sp_mem_model.sv
/*
  Instruction and data memory model, 256 words each, indexed by address bits 8..1.
  Every ack comes 0 to 3 extra cycles late; data writes are reported as one-cycle pulses.
*/

`timescale 1ns/1ns

module sp_mem_model
  import simple_processor_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_ni,
  input  logic                  imem_req_i,
  input  logic [ADDR_WIDTH-1:0] imem_addr_i,
  output logic [DATA_WIDTH-1:0] imem_rdata_o,
  output logic                  imem_ack_o,
  input  logic                  dmem_req_i,
  input  logic                  dmem_we_i,
  input  logic [ADDR_WIDTH-1:0] dmem_addr_i,
  input  logic [DATA_WIDTH-1:0] dmem_wdata_i,
  output logic [DATA_WIDTH-1:0] dmem_rdata_o,
  output logic                  dmem_ack_o,
  output logic                  wr_valid_o,
  output logic [ADDR_WIDTH-1:0] wr_addr_o,
  output logic [DATA_WIDTH-1:0] wr_data_o
);

  // Program words, written by the testbench top
  logic [DATA_WIDTH-1:0] imem [256];
  logic [DATA_WIDTH-1:0] dmem [256];
  logic [31:0]           lfsr_q = 32'haf0;
  int unsigned           i_wait = 0;
  int unsigned           d_wait = 0;

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] delay_bits(int n);
    logic [31:0] bits;
    bits = '0;
    for (int k = 0; k < n; k++) begin
      bits   = {bits[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return bits;
  endfunction

  initial begin
    imem_ack_o   = 1'b0;
    dmem_ack_o   = 1'b0;
    imem_rdata_o = '0;
    dmem_rdata_o = '0;
    wr_valid_o   = 1'b0;
    wr_addr_o    = '0;
    wr_data_o    = '0;
  end

  // Responses change 1 ns after the clock edge
  always @(posedge clk_i) begin
    #1;
    if (!arst_ni) begin
      imem_ack_o = 1'b0;
      dmem_ack_o = 1'b0;
      wr_valid_o = 1'b0;
      i_wait     = 0;
      d_wait     = 0;
      // Fill pattern from the whole byte address
      for (int i = 0; i < 256; i++) begin
        dmem[i] = 16'(i * 2) ^ 16'ha5c3;
      end
    end else begin
      wr_valid_o = 1'b0;
      // Instruction side
      if (imem_ack_o) begin
        imem_ack_o = 1'b0;
      end else if (imem_req_i) begin
        if (i_wait == 0) begin
          imem_rdata_o = imem[imem_addr_i[8:1]];
          imem_ack_o   = 1'b1;
          i_wait       = delay_bits(2);
        end else begin
          i_wait--;
        end
      end
      // Data side
      if (dmem_ack_o) begin
        dmem_ack_o = 1'b0;
      end else if (dmem_req_i) begin
        if (d_wait == 0) begin
          if (dmem_we_i) begin
            dmem[dmem_addr_i[8:1]] = dmem_wdata_i;
            wr_valid_o = 1'b1;
            wr_addr_o  = dmem_addr_i;
            wr_data_o  = dmem_wdata_i;
          end
          dmem_rdata_o = dmem[dmem_addr_i[8:1]];
          dmem_ack_o   = 1'b1;
          d_wait       = delay_bits(2);
        end else begin
          d_wait--;
        end
      end
    end
  end

endmodule

//--- design/simple_processor.sv
/*
  Multi-cycle core top. One instruction in flight, no pipelining or interrupts.
  Both memory ports hold req and address until ack; misaligned addresses pass through.
*/

`timescale 1ns/1ns

module simple_processor
  import simple_processor_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_ni,
  // Address of the first instruction after reset
  input  logic [ADDR_WIDTH-1:0] boot_addr_i,
  // Instruction port
  output logic                  imem_req_o,
  output logic [ADDR_WIDTH-1:0] imem_addr_o,
  input  logic [DATA_WIDTH-1:0] imem_rdata_i,
  input  logic                  imem_ack_i,
  // Data port
  output logic                  dmem_req_o,
  output logic                  dmem_we_o,
  output logic [ADDR_WIDTH-1:0] dmem_addr_o,
  output logic [DATA_WIDTH-1:0] dmem_wdata_o,
  input  logic [DATA_WIDTH-1:0] dmem_rdata_i,
  input  logic                  dmem_ack_i,
  // Core stopped on HALT
  output logic                  halted_o
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  logic [ADDR_WIDTH-1:0]     pc_q;
  logic [ADDR_WIDTH-1:0]     pc_next;
  logic [ADDR_WIDTH-1:0]     pc_seq;
  logic                      valid_pc;
  logic                      pc_en;
  logic                      branch_take;
  logic [ADDR_WIDTH-1:0]     branch_off;

  logic [REG_ADDR_WIDTH-1:0] rs1;
  logic [REG_ADDR_WIDTH-1:0] rs2;
  logic [REG_ADDR_WIDTH-1:0] rd;
  logic                      rf_we;
  logic                      wb_sel;
  logic [DATA_WIDTH-1:0]     rf_wd;
  logic [DATA_WIDTH-1:0]     rdata_a;
  logic [DATA_WIDTH-1:0]     rdata_b;
  logic                      rd_zero;

  alu_op_e                   alu_op;
  logic [DATA_WIDTH-1:0]     imm;
  logic                      use_imm;
  logic [DATA_WIDTH-1:0]     alu_b;
  logic [DATA_WIDTH-1:0]     alu_result;

  logic                      mem_start;
  logic                      mem_we;
  logic                      lsu_done;
  logic [DATA_WIDTH-1:0]     lsu_rdata;

  ////////////////////////////////////////
  // Program counter
  ////////////////////////////////////////

  // Fall-through address, also the base of branch targets
  assign pc_seq = pc_q + ADDR_WIDTH'(PC_STEP);

  always_comb begin
    if (!valid_pc) begin
      pc_next = boot_addr_i;
    end else if (branch_take) begin
      pc_next = pc_seq + branch_off;
    end else begin
      pc_next = pc_seq;
    end
  end

  // Cleared to zero in reset, boot address loaded one cycle later
  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      pc_q <= '0;
    end else if (pc_en) begin
      pc_q <= pc_next;
    end
  end

  assign imem_addr_o = pc_q;

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  // Second ALU operand
  assign alu_b = use_imm ? imm : rdata_b;
  // Write-back source, load data or ALU
  assign rf_wd = wb_sel ? lsu_rdata : alu_result;

  ins_dec u_ins_dec (
    .clk_i         (clk_i),
    .arst_ni       (arst_ni),
    .imem_rdata_i  (imem_rdata_i),
    .imem_ack_i    (imem_ack_i),
    .rd_zero_i     (rd_zero),
    .lsu_done_i    (lsu_done),
    .imem_req_o    (imem_req_o),
    .valid_pc_o    (valid_pc),
    .pc_en_o       (pc_en),
    .branch_take_o (branch_take),
    .branch_off_o  (branch_off),
    .rs1_o         (rs1),
    .rs2_o         (rs2),
    .rd_o          (rd),
    .rf_we_o       (rf_we),
    .wb_sel_o      (wb_sel),
    .alu_op_o      (alu_op),
    .imm_o         (imm),
    .use_imm_o     (use_imm),
    .mem_start_o   (mem_start),
    .mem_we_o      (mem_we),
    .halted_o      (halted_o)
  );

  reg_file u_reg_file (
    .clk_i     (clk_i),
    .arst_ni   (arst_ni),
    .ra_i      (rs1),
    .rb_i      (rs2),
    .we_i      (rf_we),
    .wa_i      (rd),
    .wd_i      (rf_wd),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .rd_zero_o (rd_zero)
  );

  alu u_alu (
    .op_i     (alu_op),
    .a_i      (rdata_a),
    .b_i      (alu_b),
    .result_o (alu_result)
  );

  // Store data always comes from read port b, which addresses rd for ST
  lsu u_lsu (
    .clk_i        (clk_i),
    .arst_ni      (arst_ni),
    .start_i      (mem_start),
    .we_i         (mem_we),
    .addr_i       (alu_result),
    .wdata_i      (rdata_b),
    .dmem_rdata_i (dmem_rdata_i),
    .dmem_ack_i   (dmem_ack_i),
    .dmem_req_o   (dmem_req_o),
    .dmem_we_o    (dmem_we_o),
    .dmem_addr_o  (dmem_addr_o),
    .dmem_wdata_o (dmem_wdata_o),
    .done_o       (lsu_done),
    .rdata_o      (lsu_rdata)
  );

endmodule

//--- design/ins_dec.sv
/*
  Instruction register, decoder and FETCH/EXEC/MEM/HALTED controller.
  EXEC always takes one cycle; FETCH and MEM last until the memory acks.
  HALTED is left only through reset.
*/

`timescale 1ns/1ns

module ins_dec
  import simple_processor_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_ni,
  input  logic [DATA_WIDTH-1:0]     imem_rdata_i,
  input  logic                      imem_ack_i,
  input  logic                      rd_zero_i,
  input  logic                      lsu_done_i,
  output logic                      imem_req_o,
  output logic                      valid_pc_o,
  output logic                      pc_en_o,
  output logic                      branch_take_o,
  output logic [ADDR_WIDTH-1:0]     branch_off_o,
  output logic [REG_ADDR_WIDTH-1:0] rs1_o,
  output logic [REG_ADDR_WIDTH-1:0] rs2_o,
  output logic [REG_ADDR_WIDTH-1:0] rd_o,
  output logic                      rf_we_o,
  output logic                      wb_sel_o,
  output alu_op_e                   alu_op_o,
  output logic [DATA_WIDTH-1:0]     imm_o,
  output logic                      use_imm_o,
  output logic                      mem_start_o,
  output logic                      mem_we_o,
  output logic                      halted_o
);

  ctrl_state_e           state_q;
  logic                  req_q;
  logic                  valid_pc_q;
  logic [DATA_WIDTH-1:0] ir_q;
  logic                  fetch_done;

  opcode_e               opcode;
  logic [IMM6_WIDTH-1:0] imm6;
  logic [IMM9_WIDTH-1:0] imm9;
  logic                  writes_rd;
  logic                  is_mem;
  logic                  is_store;
  logic                  is_bez;
  logic                  is_halt;

  ////////////////////////////////////////
  // Field extraction
  ////////////////////////////////////////

  assign opcode = opcode_e'(ir_q[OPC_MSB:OPC_LSB]);
  assign imm6   = ir_q[IMM6_MSB:IMM6_LSB];
  assign imm9   = ir_q[IMM9_MSB:IMM9_LSB];
  assign rd_o   = ir_q[RD_MSB:RD_LSB];
  assign rs1_o  = ir_q[RS1_MSB:RS1_LSB];
  // Port b reads rd for store data and the branch test
  assign rs2_o  = (is_store || is_bez) ? ir_q[RD_MSB:RD_LSB] : ir_q[RS2_MSB:RS2_LSB];

  // Branch distance in bytes, twice the signed immediate
  assign branch_off_o = {{(ADDR_WIDTH-IMM9_WIDTH-1){imm9[IMM9_WIDTH-1]}}, imm9, 1'b0};

  ////////////////////////////////////////
  // Opcode decode
  ////////////////////////////////////////

  always_comb begin
    alu_op_o  = ALU_ADD;
    imm_o     = {{(DATA_WIDTH-IMM6_WIDTH){imm6[IMM6_WIDTH-1]}}, imm6};
    use_imm_o = 1'b0;
    writes_rd = 1'b0;
    is_mem    = 1'b0;
    is_store  = 1'b0;
    is_bez    = 1'b0;
    is_halt   = 1'b0;
    case (opcode)
      OP_ADD: begin
        alu_op_o  = ALU_ADD;
        writes_rd = 1'b1;
      end
      OP_SUB: begin
        alu_op_o  = ALU_SUB;
        writes_rd = 1'b1;
      end
      OP_AND: begin
        alu_op_o  = ALU_AND;
        writes_rd = 1'b1;
      end
      OP_OR: begin
        alu_op_o  = ALU_OR;
        writes_rd = 1'b1;
      end
      OP_XOR: begin
        alu_op_o  = ALU_XOR;
        writes_rd = 1'b1;
      end
      OP_ADDI: begin
        use_imm_o = 1'b1;
        writes_rd = 1'b1;
      end
      // Zero-extended long immediate straight through the ALU
      OP_LDI: begin
        alu_op_o  = ALU_PASS_B;
        imm_o     = {{(DATA_WIDTH-IMM9_WIDTH){1'b0}}, imm9};
        use_imm_o = 1'b1;
        writes_rd = 1'b1;
      end
      // Address is rs1 plus the short immediate
      OP_LD: begin
        use_imm_o = 1'b1;
        is_mem    = 1'b1;
      end
      OP_ST: begin
        use_imm_o = 1'b1;
        is_mem    = 1'b1;
        is_store  = 1'b1;
      end
      OP_BEZ:  is_bez  = 1'b1;
      OP_HALT: is_halt = 1'b1;
      // NOP and unused codes
      default: ;
    endcase
  end

  ////////////////////////////////////////
  // Controller
  ////////////////////////////////////////

  assign fetch_done = req_q && imem_ack_i;

  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      state_q    <= ST_FETCH;
      req_q      <= 1'b0;
      valid_pc_q <= 1'b0;
    end else begin
      case (state_q)
        ST_FETCH: begin
          // First cycle out of reset: PC takes boot address, request starts
          if (!valid_pc_q) begin
            valid_pc_q <= 1'b1;
            req_q      <= 1'b1;
          end else if (fetch_done) begin
            req_q   <= 1'b0;
            state_q <= ST_EXEC;
          end
        end
        ST_EXEC: begin
          if (is_halt) begin
            state_q <= ST_HALTED;
          end else if (is_mem) begin
            state_q <= ST_MEM;
          end else begin
            req_q   <= 1'b1;
            state_q <= ST_FETCH;
          end
        end
        ST_MEM: begin
          if (lsu_done_i) begin
            req_q   <= 1'b1;
            state_q <= ST_FETCH;
          end
        end
        default: ;
      endcase
    end
  end

  // Instruction word is captured in the ack cycle
  always_ff @(posedge clk_i) begin
    if (fetch_done) begin
      ir_q <= imem_rdata_i;
    end
  end

  ////////////////////////////////////////
  // Control outputs
  ////////////////////////////////////////

  assign imem_req_o    = req_q;
  assign valid_pc_o    = valid_pc_q;
  // PC moves on boot and at the end of every EXEC except HALT
  assign pc_en_o       = !valid_pc_q || (state_q == ST_EXEC && !is_halt);
  assign branch_take_o = (state_q == ST_EXEC) && is_bez && rd_zero_i;
  // LD writes back at the data ack edge, everything else at the end of EXEC
  assign rf_we_o       = (state_q == ST_EXEC && writes_rd) ||
                         (state_q == ST_MEM && lsu_done_i && !is_store);
  assign wb_sel_o      = (state_q == ST_MEM);
  assign mem_start_o   = (state_q == ST_EXEC) && is_mem;
  assign mem_we_o      = is_store;
  assign halted_o      = (state_q == ST_HALTED);

endmodule

//--- design/lsu.sv
/*
  Data-port request holder. Captures one access on start_i and holds
  we, addr and wdata steady until ack; no byte enables.
*/

`timescale 1ns/1ns

module lsu
  import simple_processor_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_ni,
  input  logic                  start_i,
  input  logic                  we_i,
  input  logic [ADDR_WIDTH-1:0] addr_i,
  input  logic [DATA_WIDTH-1:0] wdata_i,
  input  logic [DATA_WIDTH-1:0] dmem_rdata_i,
  input  logic                  dmem_ack_i,
  output logic                  dmem_req_o,
  output logic                  dmem_we_o,
  output logic [ADDR_WIDTH-1:0] dmem_addr_o,
  output logic [DATA_WIDTH-1:0] dmem_wdata_o,
  output logic                  done_o,
  output logic [DATA_WIDTH-1:0] rdata_o
);

  logic                  req_q;
  logic                  we_q;
  logic [ADDR_WIDTH-1:0] addr_q;
  logic [DATA_WIDTH-1:0] wdata_q;

  ////////////////////////////////////////
  // Request state
  ////////////////////////////////////////

  // Request rises the cycle after start, drops after the ack cycle
  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      req_q <= 1'b0;
      we_q  <= 1'b0;
    end else if (start_i) begin
      req_q <= 1'b1;
      we_q  <= we_i;
    end else if (done_o) begin
      req_q <= 1'b0;
      we_q  <= 1'b0;
    end
  end

  // Address and store data
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
  end

  assign dmem_req_o   = req_q;
  assign dmem_we_o    = we_q;
  assign dmem_addr_o  = addr_q;
  assign dmem_wdata_o = wdata_q;

  // Ack closes the access; load data is taken into rd on this edge
  assign done_o  = req_q && dmem_ack_i;
  assign rdata_o = dmem_rdata_i;

endmodule

//--- design/alu.sv
/*
  Combinational ALU, all results wrap modulo 2^16.
  Also forms the LD/ST address as rs1 plus the offset.
*/

`timescale 1ns/1ns

module alu
  import simple_processor_pkg::*;
(
  input  alu_op_e               op_i,
  input  logic [DATA_WIDTH-1:0] a_i,
  input  logic [DATA_WIDTH-1:0] b_i,
  output logic [DATA_WIDTH-1:0] result_o
);

  logic [DATA_WIDTH-1:0] sum;
  logic [DATA_WIDTH-1:0] diff;

  // Carry and borrow are dropped
  assign sum  = a_i + b_i;
  assign diff = a_i - b_i;

  always_comb begin
    case (op_i)
      ALU_ADD: begin
        result_o = sum;
      end
      ALU_SUB: begin
        result_o = diff;
      end
      ALU_AND: begin
        result_o = a_i & b_i;
      end
      ALU_OR: begin
        result_o = a_i | b_i;
      end
      ALU_XOR: begin
        result_o = a_i ^ b_i;
      end
      // LDI immediate
      ALU_PASS_B: begin
        result_o = b_i;
      end
      default: begin
        result_o = '0;
      end
    endcase
  end

endmodule

//--- design/reg_file.sv
/*
  Eight 16-bit registers, two read ports and one write port.
  r0 is never written and reads as zero.
*/

`timescale 1ns/1ns

module reg_file
  import simple_processor_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_ni,
  input  logic [REG_ADDR_WIDTH-1:0] ra_i,
  input  logic [REG_ADDR_WIDTH-1:0] rb_i,
  input  logic                      we_i,
  input  logic [REG_ADDR_WIDTH-1:0] wa_i,
  input  logic [DATA_WIDTH-1:0]     wd_i,
  output logic [DATA_WIDTH-1:0]     rdata_a_o,
  output logic [DATA_WIDTH-1:0]     rdata_b_o,
  output logic                      rd_zero_o
);

  logic [DATA_WIDTH-1:0] regs_q [NUM_REGS];

  // Writes to r0 are dropped, so it keeps its reset value
  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && wa_i != '0) begin
      regs_q[wa_i] <= wd_i;
    end
  end

  // Asynchronous reads
  assign rdata_a_o = regs_q[ra_i];
  assign rdata_b_o = regs_q[rb_i];

  // Zero test of the destination field, used by BEZ
  assign rd_zero_o = (regs_q[wa_i] == '0);

endmodule

//--- design/simple_processor_pkg.sv
/*
  Shared widths, instruction encoding and controller states for the 16-bit core.
  Instructions are one 16-bit word; the PC is a byte address stepped by 2.
  Opcodes not listed in opcode_e execute as NOP.
*/

package simple_processor_pkg;

  ////////////////////////////////////////
  // Bus and register file sizes
  ////////////////////////////////////////

  localparam int ADDR_WIDTH     = 16;
  localparam int DATA_WIDTH     = 16;
  localparam int NUM_REGS       = 8;
  localparam int REG_ADDR_WIDTH = 3;

  // Byte distance between two instructions
  localparam int unsigned PC_STEP = 2;

  ////////////////////////////////////////
  // Instruction field positions
  ////////////////////////////////////////

  localparam int OPC_MSB    = 15;
  localparam int OPC_LSB    = 12;
  localparam int RD_MSB     = 11;
  localparam int RD_LSB     = 9;
  localparam int RS1_MSB    = 8;
  localparam int RS1_LSB    = 6;
  localparam int RS2_MSB    = 5;
  localparam int RS2_LSB    = 3;
  // Short immediate for ADDI, LD and ST
  localparam int IMM6_MSB   = 5;
  localparam int IMM6_LSB   = 0;
  localparam int IMM6_WIDTH = 6;
  // Long immediate for LDI and BEZ
  localparam int IMM9_MSB   = 8;
  localparam int IMM9_LSB   = 0;
  localparam int IMM9_WIDTH = 9;

  // Major opcodes
  typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_AND  = 4'd3,
    OP_OR   = 4'd4,
    OP_XOR  = 4'd5,
    OP_ADDI = 4'd6,
    OP_LDI  = 4'd7,
    OP_LD   = 4'd8,
    OP_ST   = 4'd9,
    OP_BEZ  = 4'd10,
    OP_HALT = 4'd15
  } opcode_e;

  // ALU functions
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B
  } alu_op_e;

  // Controller states
  typedef enum logic [1:0] {
    ST_FETCH,
    ST_EXEC,
    ST_MEM,
    ST_HALTED
  } ctrl_state_e;

endpackage
